// File: qsim_pkg.sv
package qsim_pkg;

    localparam int CMD_ADDR_W = 8;  // 64-bit read words.
    localparam int ENV_ADDR_W = 10; // One sample per 32-bit word.

    // Zero ends the program, so a cleared command memory stops at once.
    localparam logic [1:0] OP_END   = 2'd0;
    localparam logic [1:0] OP_PULSE = 2'd1;
    localparam logic [1:0] OP_WAIT  = 2'd2;

    typedef struct packed {
        logic [1:0]          op;
        logic signed [15:0]  amp;
        logic [ENV_ADDR_W-1:0] env_addr;
        logic [7:0]          env_len;   // 0 means 256 samples.
        logic [23:0]         phase_inc;
        logic [3:0]          pad;
    } pulse_cmd_t;

    typedef struct packed {
        logic [1:0]  op;
        logic [29:0] pad;
        logic [31:0] delay;
    } ctrl_cmd_t;

    // Op sits in the top two bits of both views.
    typedef union packed {
        pulse_cmd_t pulse;
        ctrl_cmd_t  ctrl;
    } cmd_word_t;

endpackage

// File: aligned_ram.sv
`timescale 1ns/100ps

module aligned_ram #(
    parameter int DIN_WIDTH       = 32,
    parameter int N_DIN_TO_DOUT   = 1,
    parameter int DOUT_ADDR_WIDTH = 8,
    parameter int READ_LATENCY    = 2,
    localparam int DOUT_WIDTH     = DIN_WIDTH * N_DIN_TO_DOUT,
    localparam int DIN_ADDR_WIDTH = DOUT_ADDR_WIDTH + $clog2(N_DIN_TO_DOUT)
) (
    input  logic                       clk,
    input  logic [DIN_WIDTH-1:0]       write_data,
    input  logic [DIN_ADDR_WIDTH-1:0]  write_addr,
    input  logic                       write_enable,
    input  logic [DOUT_ADDR_WIDTH-1:0] read_addr,
    output logic [DOUT_WIDTH-1:0]      read_data
);

    // Lane 0 is the least significant part of a read word.
    logic [N_DIN_TO_DOUT-1:0][DIN_WIDTH-1:0] mem [2**DOUT_ADDR_WIDTH];
    logic [DOUT_WIDTH-1:0] rd_pipe [READ_LATENCY];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr / N_DIN_TO_DOUT][write_addr % N_DIN_TO_DOUT] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[read_addr];
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign read_data = rd_pipe[READ_LATENCY-1]; // Output of the last stage.

    // Address registers upstream settle on the first reset edge.
    read_addr_known: assert property (
        @(posedge clk) 1'b1 |=> !$isunknown(read_addr)
    ) else $error("aligned_ram: read address has unknown bits");

endmodule

// File: cmd_sequencer.sv
`timescale 1ns/100ps

module cmd_sequencer import qsim_pkg::*; #(
    parameter int CMD_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stb_start,
    input  logic [31:0]           nshot,
    input  logic [63:0]           cmd_data,
    input  logic                  fetch_busy,
    input  logic                  pipe_empty,
    output logic [CMD_ADDR_W-1:0] cmd_addr,
    output logic                  pulse_stb,
    output logic signed [15:0]    pulse_amp,
    output logic [ENV_ADDR_W-1:0] pulse_env_addr,
    output logic [7:0]            pulse_env_len,
    output logic [23:0]           pulse_phase_inc,
    output logic                  busy,
    output logic                  done
);

    localparam int LAT_W = $clog2(CMD_LATENCY + 1);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_READ   = 3'd1;
    localparam logic [2:0] S_LAT    = 3'd2;
    localparam logic [2:0] S_DECODE = 3'd3;
    localparam logic [2:0] S_DELAY  = 3'd4;
    localparam logic [2:0] S_DRAIN  = 3'd5;

    logic [2:0]       state;
    logic [LAT_W-1:0] lat_cnt;
    logic [31:0]      delay_cnt;
    logic [31:0]      shot_cnt;
    logic [31:0]      shot_last;
    logic             issue;
    cmd_word_t        cmd;

    assign cmd   = cmd_data;
    assign issue = (state == S_DECODE) && (cmd.pulse.op == OP_PULSE) && !fetch_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cmd_addr  <= '0;
            lat_cnt   <= '0;
            delay_cnt <= '0;
            shot_cnt  <= '0;
            shot_last <= '0;
            pulse_stb <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            pulse_stb <= issue;
            done      <= 1'b0;
            case (state)
                S_IDLE: if (stb_start) begin
                    busy      <= 1'b1;
                    cmd_addr  <= '0;
                    shot_cnt  <= '0;
                    shot_last <= (nshot == 32'd0) ? 32'd0 : nshot - 32'd1;
                    state     <= S_READ;
                end
                S_READ: begin // Address is presented this cycle.
                    lat_cnt <= LAT_W'(1);
                    state   <= (CMD_LATENCY == 1) ? S_DECODE : S_LAT;
                end
                S_LAT: begin
                    if (lat_cnt == LAT_W'(CMD_LATENCY - 1)) state <= S_DECODE;
                    lat_cnt <= lat_cnt + LAT_W'(1);
                end
                S_DECODE: begin
                    case (cmd.pulse.op)
                        OP_PULSE: if (issue) begin // Held here while the fetch is busy.
                            cmd_addr <= cmd_addr + CMD_ADDR_W'(1);
                            state    <= S_READ;
                        end
                        OP_WAIT: begin
                            delay_cnt <= cmd.ctrl.delay;
                            cmd_addr  <= cmd_addr + CMD_ADDR_W'(1);
                            state     <= S_DELAY;
                        end
                        default: begin // END, and the unused op code.
                            if (shot_cnt == shot_last) begin
                                state <= S_DRAIN;
                            end else begin
                                shot_cnt <= shot_cnt + 32'd1;
                                cmd_addr <= '0;
                                state    <= S_READ;
                            end
                        end
                    endcase
                end
                S_DELAY: begin
                    if (delay_cnt <= 32'd1) state <= S_READ;
                    delay_cnt <= delay_cnt - 32'd1;
                end
                S_DRAIN: if (pipe_empty) begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pulse_amp       <= cmd.pulse.amp;
            pulse_env_addr  <= cmd.pulse.env_addr;
            pulse_env_len   <= cmd.pulse.env_len;
            pulse_phase_inc <= cmd.pulse.phase_inc;
        end
    end

    // The fetch stage must have finished its reads before the next pulse.
    no_stb_while_fetching: assert property (
        @(posedge clk) disable iff (!rst_n) !(pulse_stb && fetch_busy)
    ) else $error("cmd_sequencer: pulse issued while envelope fetch busy");

endmodule

// File: env_fetch.sv
`timescale 1ns/100ps

module env_fetch import qsim_pkg::*; #(
    parameter int ENV_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pulse_stb,
    input  logic signed [15:0]    pulse_amp,
    input  logic [ENV_ADDR_W-1:0] pulse_env_addr,
    input  logic [7:0]            pulse_env_len,
    input  logic [23:0]           pulse_phase_inc,
    input  logic signed [15:0]    env_data,
    output logic [ENV_ADDR_W-1:0] env_addr,
    output logic                  fetch_busy,
    output logic                  sample_valid,
    output logic signed [15:0]    sample,
    output logic                  sample_first,
    output logic signed [15:0]    sample_amp,
    output logic [23:0]           sample_phase_inc,
    output logic                  pipe_empty
);

    logic        active;
    logic [8:0]  remain;
    logic        first_q;
    logic signed [15:0] amp_q;
    logic [23:0] inc_q;

    logic [ENV_LATENCY-1:0] v_pipe;
    logic [ENV_LATENCY-1:0] f_pipe;
    logic signed [15:0]     amp_pipe [ENV_LATENCY];
    logic [23:0]            inc_pipe [ENV_LATENCY];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            remain   <= '0;
            env_addr <= '0;
            first_q  <= 1'b0;
            v_pipe   <= '0;
            f_pipe   <= '0;
        end else begin
            v_pipe[0] <= active;
            f_pipe[0] <= active & first_q;
            for (int i = 1; i < ENV_LATENCY; i++) begin
                v_pipe[i] <= v_pipe[i-1];
                f_pipe[i] <= f_pipe[i-1];
            end
            if (pulse_stb) begin
                active   <= 1'b1;
                env_addr <= pulse_env_addr;
                remain   <= (pulse_env_len == 8'd0) ? 9'd256 : {1'b0, pulse_env_len};
                first_q  <= 1'b1;
            end else if (active) begin
                env_addr <= env_addr + ENV_ADDR_W'(1); // Wraps at the top of memory.
                remain   <= remain - 9'd1;
                first_q  <= 1'b0;
                if (remain == 9'd1) active <= 1'b0;
            end
        end
    end

    // Pulse parameters ride along with each read.
    always_ff @(posedge clk) begin
        if (pulse_stb) begin
            amp_q <= pulse_amp;
            inc_q <= pulse_phase_inc;
        end
        amp_pipe[0] <= amp_q;
        inc_pipe[0] <= inc_q;
        for (int i = 1; i < ENV_LATENCY; i++) begin
            amp_pipe[i] <= amp_pipe[i-1];
            inc_pipe[i] <= inc_pipe[i-1];
        end
    end

    assign fetch_busy       = active;
    assign sample_valid     = v_pipe[ENV_LATENCY-1];
    assign sample_first     = f_pipe[ENV_LATENCY-1];
    assign sample           = env_data;
    assign sample_amp       = amp_pipe[ENV_LATENCY-1];
    assign sample_phase_inc = inc_pipe[ENV_LATENCY-1];
    assign pipe_empty       = !active && (v_pipe == '0); // No read in flight.

endmodule

// File: pulse_mixer.sv
`timescale 1ns/100ps

module pulse_mixer #(
    parameter int SHIFT = 15
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_valid,
    input  logic signed [15:0] sample,
    input  logic               sample_first,
    input  logic signed [15:0] sample_amp,
    input  logic [23:0]        sample_phase_inc,
    output logic [15:0]        dac,
    output logic               dac_valid,
    output logic               mixer_idle
);

    logic [23:0]        phase_acc;
    logic [23:0]        phase;
    logic signed [31:0] prod;
    logic signed [31:0] scaled;
    logic [15:0]        level;

    // Phase of the current sample, restarted at the first sample of a pulse.
    assign phase  = sample_first ? 24'd0 : phase_acc;
    assign prod   = sample * sample_amp;
    assign scaled = prod >>> SHIFT;
    assign level  = scaled[15:0]; // Plain cut, no saturation.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_acc  <= '0;
            dac_valid  <= 1'b0;
            mixer_idle <= 1'b1;
        end else begin
            dac_valid  <= sample_valid;
            mixer_idle <= !sample_valid;
            if (sample_valid) phase_acc <= phase + sample_phase_inc;
        end
    end

    // Upper half of the phase turn inverts the carrier.
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            dac <= phase[23] ? -level : level;
        end
    end

    // A phase restart only comes with a sample.
    first_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n) sample_first |-> sample_valid
    ) else $error("pulse_mixer: first flag without a valid sample");

endmodule

// File: pulse_gen_top.sv
`timescale 1ns/100ps

module pulse_gen_top import qsim_pkg::*; #(
    parameter int SHIFT       = 15,
    parameter int CMD_LATENCY = 2,
    parameter int ENV_LATENCY = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stb_start,
    input  logic [31:0] nshot,
    input  logic [31:0] mem_write_data,
    input  logic [15:0] mem_write_addr,
    input  logic [2:0]  mem_write_sel,  // 0 for cmd, 1 for env.
    input  logic        mem_write_en,
    output logic [15:0] dac,
    output logic        dac_valid,
    output logic        busy,
    output logic        done
);

    logic                  cmd_wen, env_wen;
    logic [CMD_ADDR_W-1:0] cmd_addr;
    logic [63:0]           cmd_data;
    logic [ENV_ADDR_W-1:0] env_addr;
    logic [31:0]           env_data;

    logic                  pulse_stb, fetch_busy, fetch_empty, mixer_idle;
    logic signed [15:0]    pulse_amp, sample, sample_amp;
    logic [ENV_ADDR_W-1:0] pulse_env_addr;
    logic [7:0]            pulse_env_len;
    logic [23:0]           pulse_phase_inc, sample_phase_inc;
    logic                  sample_valid, sample_first;

    // Host writes land only while the program is stopped.
    assign cmd_wen = mem_write_en & (mem_write_sel == 3'd0) & !busy;
    assign env_wen = mem_write_en & (mem_write_sel == 3'd1) & !busy;

    aligned_ram #(.DIN_WIDTH(32), .N_DIN_TO_DOUT(2), .DOUT_ADDR_WIDTH(CMD_ADDR_W),
                  .READ_LATENCY(CMD_LATENCY))
        cmd_mem (.clk(clk), .write_data(mem_write_data), .write_addr(mem_write_addr[CMD_ADDR_W:0]),
                 .write_enable(cmd_wen), .read_addr(cmd_addr), .read_data(cmd_data));

    aligned_ram #(.DIN_WIDTH(32), .N_DIN_TO_DOUT(1), .DOUT_ADDR_WIDTH(ENV_ADDR_W),
                  .READ_LATENCY(ENV_LATENCY))
        env_mem (.clk(clk), .write_data(mem_write_data),
                 .write_addr(mem_write_addr[ENV_ADDR_W-1:0]),
                 .write_enable(env_wen), .read_addr(env_addr), .read_data(env_data));

    cmd_sequencer #(.CMD_LATENCY(CMD_LATENCY)) seq_i (
        .clk(clk), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
        .cmd_data(cmd_data), .fetch_busy(fetch_busy),
        .pipe_empty(fetch_empty & mixer_idle),
        .cmd_addr(cmd_addr), .pulse_stb(pulse_stb), .pulse_amp(pulse_amp),
        .pulse_env_addr(pulse_env_addr), .pulse_env_len(pulse_env_len),
        .pulse_phase_inc(pulse_phase_inc), .busy(busy), .done(done));

    env_fetch #(.ENV_LATENCY(ENV_LATENCY)) fetch_i (
        .clk(clk), .rst_n(rst_n), .pulse_stb(pulse_stb), .pulse_amp(pulse_amp),
        .pulse_env_addr(pulse_env_addr), .pulse_env_len(pulse_env_len),
        .pulse_phase_inc(pulse_phase_inc), .env_data(env_data[15:0]),
        .env_addr(env_addr), .fetch_busy(fetch_busy), .sample_valid(sample_valid),
        .sample(sample), .sample_first(sample_first), .sample_amp(sample_amp),
        .sample_phase_inc(sample_phase_inc), .pipe_empty(fetch_empty));

    pulse_mixer #(.SHIFT(SHIFT)) mixer_i (
        .clk(clk), .rst_n(rst_n), .sample_valid(sample_valid), .sample(sample),
        .sample_first(sample_first), .sample_amp(sample_amp),
        .sample_phase_inc(sample_phase_inc), .dac(dac), .dac_valid(dac_valid),
        .mixer_idle(mixer_idle));

endmodule

// File: pulse_checker.sv
`timescale 1ns/100ps

module pulse_checker import qsim_pkg::*; #(
    parameter int SHIFT = 15
) (
    input logic        clk,
    input logic [15:0] dac,
    input logic        dac_valid,
    input logic        busy,
    input logic        done
);

    logic signed [15:0] env_model [2**ENV_ADDR_W]; // Low halves of the envelope words.
    logic [15:0]        exp_q [$];
    int value_errors = 0;
    int count_errors = 0;
    int other_errors = 0;
    int sample_idx   = 0;

    // Expected DAC word for sample k of a pulse.
    function automatic logic [15:0] mixed_sample(input logic signed [15:0] env,
            input logic signed [15:0] amp, input logic [23:0] inc, input int k);
        logic [31:0]        phase;
        logic signed [31:0] prod;
        logic signed [31:0] shifted;
        phase   = k * inc; // Bits above 23 do not matter.
        prod    = env * amp;
        shifted = prod >>> SHIFT;
        return phase[23] ? -shifted[15:0] : shifted[15:0];
    endfunction

    task automatic note_env(input logic [ENV_ADDR_W-1:0] addr, input logic signed [15:0] value);
        env_model[addr] = value;
    endtask

    task automatic expect_pulse(input logic signed [15:0] amp, input logic [ENV_ADDR_W-1:0] base,
                                input logic [7:0] len, input logic [23:0] inc);
        int n;
        n = (len == 8'd0) ? 256 : int'(len);
        for (int k = 0; k < n; k++) begin
            exp_q.push_back(mixed_sample(env_model[ENV_ADDR_W'(base + k)], amp, inc, k));
        end
    endtask

    task automatic note_failure(input string msg);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    always @(negedge clk) begin : compare
        logic [15:0] want;
        if (dac_valid) begin
            if (!busy) note_failure("DAC sample appeared while busy was low");
            if (exp_q.size() == 0) begin
                count_errors++;
                $display("ERROR at %0t ns: extra DAC sample %0d with nothing expected",
                         $time, $signed(dac));
            end else begin
                want = exp_q.pop_front();
                if (dac !== want) begin
                    value_errors++;
                    $display("CHECK FAILED at %0t ns: sample %0d expected %0d, got %0d",
                             $time, sample_idx, $signed(want), $signed(dac));
                end
                sample_idx++;
            end
        end
        if (done && exp_q.size() != 0) begin
            count_errors++;
            $display("ERROR at %0t ns: done came early, %0d samples still missing",
                     $time, exp_q.size());
        end
    end

endmodule

// File: tb_pulse_gen.sv
`timescale 1ns/100ps

module tb_pulse_gen import qsim_pkg::*; ();

    localparam int SHIFT = 15;

    logic        clk, rst_n, stb_start, mem_write_en, dac_valid, busy, done;
    logic [31:0] nshot, mem_write_data;
    logic [15:0] mem_write_addr, dac;
    logic [2:0]  mem_write_sel;

    logic [31:0]        lcg_state = 32'd55973;
    int                 work_cycles = 0;
    int                 n_pulses = 0;
    int                 n_cmds = 0;
    int                 wait_sum = 0;
    logic signed [15:0] prog_amp [16];
    logic [9:0]         prog_base [16];
    logic [7:0]         prog_len [16];
    logic [23:0]        prog_inc [16];

    pulse_gen_top #(.SHIFT(SHIFT), .CMD_LATENCY(2), .ENV_LATENCY(2)) dut_i (
        .clk(clk), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
        .mem_write_data(mem_write_data), .mem_write_addr(mem_write_addr),
        .mem_write_sel(mem_write_sel), .mem_write_en(mem_write_en),
        .dac(dac), .dac_valid(dac_valid), .busy(busy), .done(done));

    pulse_checker #(.SHIFT(SHIFT)) check_i (
        .clk(clk), .dac(dac), .dac_valid(dac_valid), .busy(busy), .done(done));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16); // Fold the better upper bits down.
    endfunction

    task automatic host_write(input logic [2:0] sel, input logic [15:0] addr,
                              input logic [31:0] data);
        work_cycles++;
        mem_write_en   = 1'b1;
        mem_write_sel  = sel;
        mem_write_addr = addr;
        mem_write_data = data;
        @(negedge clk);
        mem_write_en = 1'b0;
    endtask

    task automatic write_env(input int addr, input logic [31:0] data);
        host_write(3'd1, 16'(addr), data);
        check_i.note_env(ENV_ADDR_W'(addr), data[15:0]);
    endtask

    task automatic put_cmd(input logic [63:0] word);
        host_write(3'd0, 16'(2 * n_cmds), word[31:0]);     // Low half first.
        host_write(3'd0, 16'(2 * n_cmds + 1), word[63:32]);
        n_cmds++;
    endtask

    task automatic add_pulse(input logic signed [15:0] amp, input logic [9:0] base,
                             input logic [7:0] len, input logic [23:0] inc);
        put_cmd({OP_PULSE, amp, base, len, inc, 4'h0});
        prog_amp[n_pulses]  = amp;
        prog_base[n_pulses] = base;
        prog_len[n_pulses]  = len;
        prog_inc[n_pulses]  = inc;
        n_pulses++;
    endtask

    task automatic add_wait(input logic [31:0] delay);
        put_cmd({OP_WAIT, 30'd0, delay});
        wait_sum += delay;
    endtask

    task automatic run_program(input logic [31:0] shots, input bit poke_start);
        int reps;
        put_cmd({OP_END, 62'd0});
        reps = (shots == 0) ? 1 : int'(shots);
        for (int s = 0; s < reps; s++) begin
            for (int p = 0; p < n_pulses; p++) begin
                check_i.expect_pulse(prog_amp[p], prog_base[p], prog_len[p], prog_inc[p]);
                work_cycles += (prog_len[p] == 8'd0) ? 256 : int'(prog_len[p]);
            end
            work_cycles += wait_sum + 8 * n_cmds;
        end
        nshot     = shots;
        stb_start = 1'b1;
        @(negedge clk);
        stb_start = 1'b0;
        if (!busy) check_i.note_failure("busy did not rise after the start strobe");
        if (poke_start) begin // A second start while running must be ignored.
            repeat (3) @(negedge clk);
            stb_start = 1'b1;
            nshot     = 32'd7;
            @(negedge clk);
            stb_start = 1'b0;
        end
        while (done !== 1'b1) @(negedge clk);
        repeat (12) @(negedge clk);
        if (busy) check_i.note_failure("busy still high after done");
        n_pulses = 0;
        n_cmds   = 0;
        wait_sum = 0;
    endtask

    initial begin
        while (($time / 8) <= 4 * work_cycles + 2000) @(posedge clk);
        $display("ERROR: timeout, run did not finish within %0d cycles", 4 * work_cycles + 2000);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int errors;
        rst_n          = 1'b0;
        stb_start      = 1'b0;
        nshot          = 32'd0;
        mem_write_en   = 1'b0;
        mem_write_sel  = 3'd0;
        mem_write_addr = 16'd0;
        mem_write_data = 32'd0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int a = 0; a < 2**ENV_ADDR_W; a++) write_env(a, next_rand());

        add_pulse(16'(1 + next_rand() % 32767), 10'(next_rand()), 8'(1 + next_rand() % 40), 24'd0);
        run_program(32'd1, 1'b0);

        add_pulse(16'sd20000, 10'(next_rand()), 8'd24, 24'h200000 | 24'(next_rand() % 24'h80000));
        add_pulse(16'sd9000, 10'(next_rand()), 8'd17, 24'(next_rand()));
        run_program(32'd1, 1'b0);

        add_pulse(16'sd12345, 10'(next_rand()), 8'(1 + next_rand() % 30), 24'(next_rand()));
        add_wait(32'd5 + next_rand() % 20);
        add_pulse(16'sd30000, 10'(next_rand()), 8'(1 + next_rand() % 30), 24'(next_rand()));
        run_program(32'd1, 1'b0);

        add_pulse(16'sd16384, 10'd300, 8'd0, 24'h0A0000);
        run_program(32'd3, 1'b0);

        add_pulse(-16'sd7000, 10'd64, 8'd12, 24'h300000);
        host_write(3'd2, 16'd0, next_rand()); // Unused selects must not reach either memory.
        host_write(3'd5, 16'd1, next_rand());
        host_write(3'd7, 16'd70, next_rand());
        run_program(32'd1, 1'b1);

        write_env(1020, {16'(next_rand()), 16'h7FFF});
        write_env(1021, {16'(next_rand()), 16'h8000});
        write_env(1022, {16'(next_rand()), 16'h8001});
        write_env(1023, {16'(next_rand()), 16'hFFFF});
        add_pulse(-16'sd32768, 10'd1020, 8'd8, 24'd0); // Runs past the top address.
        add_pulse(16'sh8001, 10'd1020, 8'd4, 24'h600000);
        add_pulse(16'sh7FFF, 10'd1020, 8'd4, 24'd0);
        run_program(32'd1, 1'b0);

        for (int p = 0; p < 3; p++) begin
            add_pulse(16'(next_rand()), 10'(next_rand()), 8'(next_rand()), 24'(next_rand()));
        end
        run_program(next_rand() % 3, 1'b0);

        errors = check_i.value_errors + check_i.count_errors + check_i.other_errors;
        $display("Errors: %0d wrong samples, %0d missing or extra, %0d other (%0d samples seen)",
                 check_i.value_errors, check_i.count_errors, check_i.other_errors,
                 check_i.sample_idx);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
qsim_pkg.sv
aligned_ram.sv
cmd_sequencer.sv
env_fetch.sv
pulse_mixer.sv
pulse_gen_top.sv
pulse_checker.sv
tb_pulse_gen.sv

// File: Bender.yml
package:
  name: pulse_gen

sources:
  - qsim_pkg.sv
  - aligned_ram.sv
  - cmd_sequencer.sv
  - env_fetch.sv
  - pulse_mixer.sv
  - pulse_gen_top.sv
  - target: simulation
    files:
      - pulse_checker.sv
      - tb_pulse_gen.sv
